/* rtl/cache_pkg.sv */
package cache_pkg;

  // Cache geometry
  localparam int SET_NUM = 8;                        // Sets in the cache
  localparam int WAY_NUM = 2;                        // Ways per set
  localparam int INDEX_W = $clog2(SET_NUM);          // Set index from addr[4:2]
  localparam int TAG_W   = 32 - INDEX_W - 2;         // Tag from addr[31:5]

  // Backing memory
  localparam int MEM_WORDS   = 256;                  // Word depth so addresses above 1 KB alias
  localparam int MEM_ADDR_W  = $clog2(MEM_WORDS);    // Word address width
  localparam int MEM_LATENCY = 4;                    // Cycles from read command to rvalid

  // Controller states
  typedef enum logic [1:0] {
    CS_IDLE,                                         // Waiting for a request
    CS_RESPOND,                                      // Lookup and hit or store response
    CS_REFILL,                                       // Waiting on memory read
    CS_FILL                                          // Line write and miss response
  } cache_state_t;

endpackage

/* rtl/cache_array_if.sv */
`timescale 1ns/1ps

interface cache_array_if;
  import cache_pkg::*;

  // Controller side
  logic [INDEX_W-1:0] index;                         // Registered set index
  logic [TAG_W-1:0]   tag;                           // Registered tag
  logic [1:0]         byte_sel;                      // Byte within the word
  logic               fill_en;                       // Write a refilled line
  logic               fill_way;                      // Way to fill
  logic [31:0]        fill_data;                     // Refilled word
  logic               store_en;                      // Merge a byte into the hit line
  logic [7:0]         store_byte;                    // Byte to merge

  // Store side
  logic               hit;                           // Indexed set holds the tag
  logic               hit_way;                       // Way that matched
  logic               victim_way;                    // LRU way of the set
  logic [31:0]        rd_byte;                       // Selected byte, zero-extended

  modport controller (
    output index, tag, byte_sel, fill_en, fill_way, fill_data, store_en, store_byte,
    input  hit, hit_way, victim_way, rd_byte
  );

  modport store (
    input  index, tag, byte_sel, fill_en, fill_way, fill_data, store_en, store_byte,
    output hit, hit_way, victim_way, rd_byte
  );

endinterface

/* rtl/cache_tag_store.sv */
`timescale 1ns/1ps

module cache_tag_store (
  input  logic          clk,
  input  logic          reset,
  cache_array_if.store  arr
);
  import cache_pkg::*;

  logic [SET_NUM-1:0][WAY_NUM-1:0] valid;            // Line valid bits
  logic [SET_NUM-1:0]              lru;              // Next victim way per set
  logic [TAG_W-1:0]                tag_mem [SET_NUM][WAY_NUM];
  logic [31:0]                     data_mem [SET_NUM][WAY_NUM];

  // Both ways compared in parallel
  always_comb begin
    arr.hit     = 1'b0;
    arr.hit_way = 1'b0;
    for (int w = 0; w < WAY_NUM; w++) begin
      if (valid[arr.index][w] && tag_mem[arr.index][w] == arr.tag) begin
        arr.hit     = 1'b1;
        arr.hit_way = 1'(w);                         // At most one way matches
      end
    end
  end

  assign arr.victim_way = lru[arr.index];            // LRU bit names the victim
  assign arr.rd_byte    = {24'b0, data_mem[arr.index][arr.hit_way][arr.byte_sel*8 +: 8]};

  // Valid and LRU state
  always_ff @(posedge clk) begin
    if (reset) begin
      valid <= '0;
      lru   <= '0;
    end else if (arr.fill_en) begin
      valid[arr.index][arr.fill_way] <= 1'b1;
      lru[arr.index]                 <= ~arr.fill_way;  // Other way is next victim
    end else if (arr.hit) begin
      // Index and tag stay registered between requests, so a repeated
      // update while idle writes the same value again
      lru[arr.index] <= ~arr.hit_way;
    end
  end

  // Tag and data arrays
  always_ff @(posedge clk) begin
    if (arr.fill_en) begin
      tag_mem[arr.index][arr.fill_way]  <= arr.tag;
      data_mem[arr.index][arr.fill_way] <= arr.fill_data;
    end
    if (arr.store_en) begin
      data_mem[arr.index][arr.hit_way][arr.byte_sel*8 +: 8] <= arr.store_byte;  // Byte merge
    end
  end

endmodule

/* rtl/cache_controller.sv */
`timescale 1ns/1ps

module cache_controller (
  input  logic                              clk,
  input  logic                              reset,
  input  logic                              req_load,
  input  logic                              req_store,
  input  logic [31:0]                       req_addr,
  input  logic [7:0]                        req_wdata,
  output logic                              busy,
  output logic                              resp_valid,
  output logic                              resp_hit,
  output logic [31:0]                       resp_data,
  output logic                              mem_read,
  output logic                              mem_write,
  output logic [cache_pkg::MEM_ADDR_W-1:0]  mem_addr,
  output logic [7:0]                        mem_wdata,
  output logic [1:0]                        mem_byte_sel,
  input  logic                              mem_rvalid,
  input  logic [31:0]                       mem_rdata,
  cache_array_if.controller                 arr
);
  import cache_pkg::*;

  cache_state_t       state;
  logic               accept;                        // Request taken this edge
  logic               is_store_q;                    // Registered operation
  logic [INDEX_W-1:0] index_q;
  logic [TAG_W-1:0]   tag_q;
  logic [1:0]         byte_sel_q;
  logic [7:0]         wdata_q;
  logic [31:0]        refill_q;                      // Word returned by memory

  assign accept = (state == CS_IDLE) && (req_load ^ req_store);  // Exactly one strobe
  assign busy   = (state != CS_IDLE);

  always_ff @(posedge clk) begin
    if (reset) begin
      state      <= CS_IDLE;
      resp_valid <= 1'b0;
    end else begin
      resp_valid <= 1'b0;                            // One-cycle pulse
      case (state)
        CS_IDLE: begin
          if (accept) state <= CS_RESPOND;
        end
        CS_RESPOND: begin
          if (is_store_q || arr.hit) begin
            state      <= CS_IDLE;
            resp_valid <= 1'b1;
          end else begin
            state <= CS_REFILL;                      // Read issued this cycle
          end
        end
        CS_REFILL: begin
          if (mem_rvalid) state <= CS_FILL;
        end
        CS_FILL: begin
          state      <= CS_IDLE;
          resp_valid <= 1'b1;
        end
        default: state <= CS_IDLE;
      endcase
    end
  end

  // Request, refill and response payload
  always_ff @(posedge clk) begin
    if (accept) begin
      is_store_q <= req_store;
      index_q    <= req_addr[INDEX_W+1:2];
      tag_q      <= req_addr[31:INDEX_W+2];
      byte_sel_q <= req_addr[1:0];
      wdata_q    <= req_wdata;
    end
    if (state == CS_REFILL && mem_rvalid) refill_q <= mem_rdata;
    if (state == CS_RESPOND) begin
      resp_hit  <= arr.hit;                          // Store reports line presence
      resp_data <= is_store_q ? {24'b0, wdata_q} : arr.rd_byte;
    end
    if (state == CS_FILL) begin
      resp_hit  <= 1'b0;
      resp_data <= {24'b0, refill_q[byte_sel_q*8 +: 8]};
    end
  end

  // Memory commands
  assign mem_read     = (state == CS_RESPOND) && !is_store_q && !arr.hit;
  assign mem_write    = (state == CS_RESPOND) && is_store_q;  // Write-through always
  assign mem_addr     = {tag_q[MEM_ADDR_W-INDEX_W-1:0], index_q};
  assign mem_wdata    = wdata_q;
  assign mem_byte_sel = byte_sel_q;

  // Store array side
  assign arr.index      = index_q;
  assign arr.tag        = tag_q;
  assign arr.byte_sel   = byte_sel_q;
  assign arr.fill_en    = (state == CS_FILL);
  assign arr.fill_way   = arr.victim_way;            // Set untouched during refill
  assign arr.fill_data  = refill_q;
  assign arr.store_en   = mem_write && arr.hit;      // No allocate on store miss
  assign arr.store_byte = wdata_q;

endmodule

/* rtl/data_memory.sv */
`timescale 1ns/1ps

module data_memory (
  input  logic                              clk,
  input  logic                              reset,
  input  logic                              read,
  input  logic                              write,
  input  logic [cache_pkg::MEM_ADDR_W-1:0]  addr,
  input  logic [7:0]                        wdata,
  input  logic [1:0]                        byte_sel,
  output logic                              rvalid,
  output logic [31:0]                       rdata
);
  import cache_pkg::*;

  logic [31:0]                       mem [MEM_WORDS];
  logic [$clog2(MEM_LATENCY+1)-1:0]  count;          // Cycles left on pending read
  logic [MEM_ADDR_W-1:0]             raddr_q;        // Address of pending read
  logic                              read_start;

  // Byte b of word k holds k
  initial begin
    for (int k = 0; k < MEM_WORDS; k++) begin
      mem[k] = 32'(k) * 32'h0101_0101;
    end
  end

  assign read_start = read && (count == '0);         // Busy memory drops new reads

  always_ff @(posedge clk) begin
    if (reset) begin
      count <= '0;
    end else if (read_start) begin
      count <= ($bits(count))'(MEM_LATENCY);
    end else if (count != '0) begin
      count <= count - 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (read_start) raddr_q <= addr;
    if (write) mem[addr][byte_sel*8 +: 8] <= wdata;  // Byte merge on the pulse
  end

  assign rvalid = (count == 1);                      // Last cycle of the countdown
  assign rdata  = mem[raddr_q];

endmodule

/* rtl/cache_subsystem_top.sv */
`timescale 1ns/1ps

module cache_subsystem_top (
  input  logic        clk,
  input  logic        reset,
  input  logic        req_load,
  input  logic        req_store,
  input  logic [31:0] req_addr,
  input  logic [7:0]  req_wdata,
  output logic        busy,
  output logic        resp_valid,
  output logic        resp_hit,
  output logic [31:0] resp_data
);
  import cache_pkg::*;

  logic                  mem_read;
  logic                  mem_write;
  logic [MEM_ADDR_W-1:0] mem_addr;
  logic [7:0]            mem_wdata;
  logic [1:0]            mem_byte_sel;
  logic                  mem_rvalid;
  logic [31:0]           mem_rdata;

  cache_array_if arr_if ();                          // Controller to store bundle

  cache_controller u_controller (
    .clk          (clk),
    .reset        (reset),
    .req_load     (req_load),
    .req_store    (req_store),
    .req_addr     (req_addr),
    .req_wdata    (req_wdata),
    .busy         (busy),
    .resp_valid   (resp_valid),
    .resp_hit     (resp_hit),
    .resp_data    (resp_data),
    .mem_read     (mem_read),
    .mem_write    (mem_write),
    .mem_addr     (mem_addr),
    .mem_wdata    (mem_wdata),
    .mem_byte_sel (mem_byte_sel),
    .mem_rvalid   (mem_rvalid),
    .mem_rdata    (mem_rdata),
    .arr          (arr_if.controller)
  );

  cache_tag_store u_tag_store (
    .clk   (clk),
    .reset (reset),
    .arr   (arr_if.store)
  );

  data_memory u_data_memory (
    .clk      (clk),
    .reset    (reset),
    .read     (mem_read),
    .write    (mem_write),
    .addr     (mem_addr),
    .wdata    (mem_wdata),
    .byte_sel (mem_byte_sel),
    .rvalid   (mem_rvalid),
    .rdata    (mem_rdata)
  );

endmodule

/* sim/cache_assertions.sv */
`timescale 1ns/1ps

module cache_assertions (
  input logic                    clk,
  input logic                    reset,
  input cache_pkg::cache_state_t state,
  input logic                    busy,
  input logic                    req_load,
  input logic                    req_store,
  input logic                    resp_valid,
  input logic                    mem_read,
  input logic                    mem_rvalid
);
  import cache_pkg::*;

  int fail_count = 0;                                // Failed assertion count

  // An accepted request starts the lookup on the next edge
  accept_to_respond: assert property (@(posedge clk) disable iff (reset)
    (!busy && (req_load ^ req_store)) |=> (busy && state == CS_RESPOND))
    else begin
      $error("accepted request left the controller in state %s", state.name());
      fail_count++;
    end

  one_strobe: assert property (@(posedge clk) disable iff (reset)
    !(req_load && req_store))
    else begin
      $error("req_load and req_store high together");
      fail_count++;
    end

  resp_pulse: assert property (@(posedge clk) disable iff (reset)
    resp_valid |=> !resp_valid)
    else begin
      $error("resp_valid held longer than one cycle");
      fail_count++;
    end

  // Read data valid exactly MEM_LATENCY cycles after every read and never otherwise
  read_latency: assert property (@(posedge clk) disable iff (reset)
    mem_rvalid == $past(mem_read, MEM_LATENCY))
    else begin
      $error("mem_rvalid not MEM_LATENCY cycles after mem_read");
      fail_count++;
    end

endmodule

bind cache_controller cache_assertions u_assertions (
  .clk        (clk),
  .reset      (reset),
  .state      (state),
  .busy       (busy),
  .req_load   (req_load),
  .req_store  (req_store),
  .resp_valid (resp_valid),
  .mem_read   (mem_read),
  .mem_rvalid (mem_rvalid)
);

/* sim/cache_tb.sv */
`timescale 1ns/1ps

module cache_tb;
  import cache_pkg::*;

  localparam int WAIT_LIMIT = 40;                    // Cycles before a wait gives up
  localparam int RANDOM_OPS = 200;

  logic        clk;
  logic        reset;
  logic        req_load;
  logic        req_store;
  logic [31:0] req_addr;
  logic [7:0]  req_wdata;
  logic        busy;
  logic        resp_valid;
  logic        resp_hit;
  logic [31:0] resp_data;

  logic [31:0]      ref_mem [MEM_WORDS];             // Write-through memory image
  logic             ref_valid [SET_NUM][WAY_NUM];
  logic [TAG_W-1:0] ref_tag [SET_NUM][WAY_NUM];
  logic             ref_lru [SET_NUM];               // Next victim per set
  int               data_errors = 0;
  int               hit_errors = 0;
  int               other_errors = 0;                // Timeouts, busy and stimulus file problems

  cache_subsystem_top UUT (
    .clk        (clk),
    .reset      (reset),
    .req_load   (req_load),
    .req_store  (req_store),
    .req_addr   (req_addr),
    .req_wdata  (req_wdata),
    .busy       (busy),
    .resp_valid (resp_valid),
    .resp_hit   (resp_hit),
    .resp_data  (resp_data)
  );

  always #50 clk = ~clk;                             // 100 ns period

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    return y ^ (y << 5);
  endfunction

  // Predicts data and hit flag of one access, then updates the model
  task automatic model_access(input logic st, input logic [31:0] a, input logic [7:0] wd,
                              output logic [31:0] exp_data, output logic exp_hit);
    logic way;
    exp_hit = 1'b0;
    way     = ref_lru[a[4:2]];                       // Victim unless a way hits
    for (int w = 0; w < WAY_NUM; w++) begin
      if (ref_valid[a[4:2]][w] && ref_tag[a[4:2]][w] == a[31:5]) begin
        exp_hit = 1'b1;
        way     = 1'(w);
      end
    end
    if (st) begin
      ref_mem[a[9:2]][{a[1:0], 3'b000} +: 8] = wd;   // Memory always written
    end else if (!exp_hit) begin
      ref_valid[a[4:2]][way] = 1'b1;                 // Load miss fills the victim
      ref_tag[a[4:2]][way]   = a[31:5];
    end
    if (exp_hit || !st) begin
      ref_lru[a[4:2]] = ~way;                        // Store miss leaves LRU alone
    end
    exp_data = {24'd0, ref_mem[a[9:2]][{a[1:0], 3'b000} +: 8]};
  endtask

  task automatic check_byte(input logic [31:0] got, input logic [31:0] exp, input string op_name);
    if (got !== exp) begin
      data_errors++;
      $display("MISMATCH at %0t: %s returned data %h, expected %h", $time, op_name, got, exp);
    end
  endtask

  task automatic check_hit(input logic got, input logic exp, input string op_name);
    if (got !== exp) begin
      hit_errors++;
      $display("MISMATCH at %0t: %s returned hit %b, expected %b", $time, op_name, got, exp);
    end
  endtask

  // Waits for idle, drives the strobes for one edge, waits for the response
  task automatic run_op(input logic st, input logic [31:0] a, input logic [7:0] wd,
                        output logic [31:0] got_data, output logic got_hit, output logic ok);
    int n;
    got_data = '0;
    got_hit  = 1'b0;
    n        = 0;
    @(negedge clk);
    while (busy && n < WAIT_LIMIT) begin
      @(negedge clk);
      n++;
    end
    ok = !busy;
    if (!ok) begin
      other_errors++;
      $display("Timeout at %0t: busy stayed high, request for %h not issued", $time, a);
    end else begin
      @(posedge clk);
      req_load  <= !st;
      req_store <= st;
      req_addr  <= a;
      req_wdata <= wd;
      @(posedge clk);                                // Accepted on this edge
      req_load  <= 1'b0;
      req_store <= 1'b0;
      n = 0;
      @(negedge clk);
      if (!busy) begin
        other_errors++;
        $display("At %0t busy was low after the request for %h was accepted", $time, a);
      end
      while (!resp_valid && n < WAIT_LIMIT) begin
        @(negedge clk);
        n++;
      end
      ok       = resp_valid;
      got_data = resp_data;
      got_hit  = resp_hit;
      if (!ok) begin
        other_errors++;
        $display("Timeout at %0t: no response to request for address %h", $time, a);
      end
    end
  endtask

  initial begin
    int          fd;
    int          n;
    int          line_no;
    string       line;
    logic [31:0] f_op;
    logic [31:0] f_addr;
    logic [31:0] f_wdata;
    logic [31:0] f_data;
    logic [31:0] f_hit;
    logic [31:0] rng;
    logic [31:0] a;
    logic [31:0] exp_data;
    logic [31:0] got_data;
    logic        exp_hit;
    logic        got_hit;
    logic        ok;
    logic        st;
    clk       = 1'b0;
    reset     = 1'b1;
    req_load  = 1'b0;
    req_store = 1'b0;
    req_addr  = '0;
    req_wdata = '0;
    for (int k = 0; k < MEM_WORDS; k++) begin
      ref_mem[k] = {4{8'(k)}};                       // Byte b of word k is k
    end
    for (int s = 0; s < SET_NUM; s++) begin
      ref_lru[s]   = 1'b0;
      ref_valid[s] = '{1'b0, 1'b0};
    end
    repeat (3) @(posedge clk);
    reset <= 1'b0;

    // Directed phase from the stimulus file
    fd = $fopen("sim/cache_stimulus.txt", "r");
    if (fd == 0) begin
      other_errors++;
      $display("Could not open stimulus file sim/cache_stimulus.txt");
    end else begin
      line_no = 0;
      while (!$feof(fd) && other_errors == 0) begin
        line = "";
        n    = $fgets(line, fd);
        line_no++;
        if (n > 1 && line[0] != "#") begin           // Skip comments and blank lines
          n = $sscanf(line, "%h %h %h %h %h", f_op, f_addr, f_wdata, f_data, f_hit);
          if (n != 5) begin
            other_errors++;
            $display("Stimulus line %0d has %0d fields instead of 5", line_no, n);
          end else begin
            model_access(f_op[0], f_addr, f_wdata[7:0], exp_data, exp_hit);  // Keep model in step
            run_op(f_op[0], f_addr, f_wdata[7:0], got_data, got_hit, ok);
            if (ok) begin
              check_byte(got_data, f_data, $sformatf("stimulus line %0d", line_no));
              check_hit(got_hit, f_hit[0], $sformatf("stimulus line %0d", line_no));
            end
          end
        end
      end
      $fclose(fd);
    end

    // Random phase against the reference model
    rng = 32'h5e4f_aa23;
    for (int i = 0; i < RANDOM_OPS && other_errors == 0; i++) begin
      rng = xorshift(rng);
      st  = (rng[30:29] == 2'b00);                   // About one store in four
      a   = {22'd0, rng[12:11], 3'd0, rng[4:0]};     // Four tags per set within 1 KB
      model_access(st, a, rng[23:16], exp_data, exp_hit);
      run_op(st, a, rng[23:16], got_data, got_hit, ok);
      if (ok) begin
        check_byte(got_data, exp_data, $sformatf("random op %0d", i));
        check_hit(got_hit, exp_hit, $sformatf("random op %0d", i));
      end
    end

    n = data_errors + hit_errors + other_errors + UUT.u_controller.u_assertions.fail_count;
    $display("Errors: data %0d, hit flag %0d, other %0d, assertion %0d", data_errors,
             hit_errors, other_errors, UUT.u_controller.u_assertions.fail_count);
    if (n == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

/* sim/cache_stimulus.txt */
# Columns: op (0 load, 1 store), byte address, write byte, expected byte, expected hit
# All fields hex; memory starts with every byte of word k equal to k
# Cold miss then hits in set 3
0 0000004c 00 13 0
0 0000004c 00 13 1
0 0000004d 00 13 1
# Three tags in set 1, LRU victim selection
0 00000004 00 01 0
0 00000024 00 09 0
0 00000004 00 01 1
0 00000044 00 11 0
0 00000004 00 01 1
0 00000024 00 09 0
# Store hit merges one byte, neighbours unchanged
1 0000004e a5 a5 1
0 0000004e 00 a5 1
0 0000004c 00 13 1
0 0000004d 00 13 1
0 0000004f 00 13 1
# Store miss writes memory only, no allocate
1 000000f1 5a 5a 0
0 000000f1 00 5a 0
0 000000f0 00 3c 1
0 000000f1 00 5a 1
# Top of the 1 KB window
0 000003ff 00 ff 0
0 000003fc 00 ff 1

/* cache_subsystem.f */
rtl/cache_pkg.sv
rtl/cache_array_if.sv
rtl/cache_tag_store.sv
rtl/cache_controller.sv
rtl/data_memory.sv
rtl/cache_subsystem_top.sv
sim/cache_assertions.sv
sim/cache_tb.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module cache_tb -f cache_subsystem.f -o cache_sim

status=0
output=$(./obj_dir/cache_sim +verilator+error+limit+1000 2>&1) || status=$?
printf '%s\n' "$output"

if printf '%s\n' "$output" | grep -qx "Test completed successfully"; then
  exit 0
fi
echo "Simulation did not report success (exit status $status)"
exit 1
